// File: rtl/ahb_pkg.sv
package ahb_pkg;

    // Basic bus words
    typedef logic [31:0] haddr_t;
    typedef logic [31:0] hdata_t;
    typedef logic [3:0]  hstrb_t;
    typedef logic [15:0] paddr_t;

    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_e;

    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    // --------------------------------------------------------------------
    // AHB-Lite address phase and slave response
    // --------------------------------------------------------------------
    typedef struct packed {
        haddr_t  haddr;
        htrans_e htrans;
        hsize_e  hsize;
        logic    hwrite;
    } ahb_req_t;

    typedef struct packed {
        logic   hready;
        hresp_e hresp;
        hdata_t hrdata;
    } ahb_rsp_t;

    // --------------------------------------------------------------------
    // APB request and completer response
    // --------------------------------------------------------------------
    typedef struct packed {
        paddr_t paddr;
        logic   psel;
        logic   penable;
        logic   pwrite;
        hdata_t pwdata;
        hstrb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        logic   pready;
        logic   pslverr;
        hdata_t prdata;
    } apb_rsp_t;

    // Byte lanes touched by a transfer of the given size and low address
    function automatic hstrb_t size_to_strb(input hsize_e size, input logic [1:0] addr_lo);
        hstrb_t strb;
        case (size)
            HSIZE_BYTE: strb = 4'b0001 << addr_lo;
            HSIZE_HALF: strb = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:    strb = 4'b1111;
        endcase
        return strb;
    endfunction

endpackage

// File: rtl/soc_map_pkg.sv
package soc_map_pkg;

    // --------------------------------------------------------------------
    // AHB address map selected by the top address nibble
    // --------------------------------------------------------------------
    localparam int REGION_LSB = 28;

    typedef enum logic [3:0] {
        REGION_ITCM = 4'h0,
        REGION_DTCM = 4'h2,
        REGION_APB  = 4'h4
    } region_e;

    // Data-phase owner and index of each real slave's select
    typedef enum logic [1:0] {
        ITCM    = 2'd0,
        DTCM    = 2'd1,
        APB     = 2'd2,
        DEFAULT = 2'd3
    } slave_idx_e;

    // --------------------------------------------------------------------
    // APB slots inside the bridge region
    // --------------------------------------------------------------------
    localparam int         APB_SLOT_LSB = 16;
    localparam logic [3:0] APB_SLOT_MEM = 4'd3;

    // Default memory depths in words
    localparam int ITCM_WORDS    = 64;
    localparam int DTCM_WORDS    = 64;
    localparam int APB_MEM_WORDS = 32;

    // Width of the APB divide factor
    localparam int DIV_WIDTH = 4;

endpackage

// File: rtl/ahb_decoder.sv
`timescale 1ns/10ps

module ahb_decoder (
    input  logic              clk,
    input  logic              RSTn,
    input  ahb_pkg::ahb_req_t bus_req_i,
    output logic [2:0]        hsel_o,
    input  ahb_pkg::ahb_rsp_t itcm_rsp_i,
    input  ahb_pkg::ahb_rsp_t dtcm_rsp_i,
    input  ahb_pkg::ahb_rsp_t apb_rsp_i,
    output ahb_pkg::ahb_rsp_t bus_rsp_o
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [1:0] {
        ERR_IDLE,
        ERR_WAIT,
        ERR_LAST
    } err_state_e;

    logic [3:0] region;
    logic       trans_valid;
    slave_idx_e owner_d;
    slave_idx_e owner_q;
    err_state_e err_q;

    assign region      = bus_req_i.haddr[REGION_LSB +: 4];
    assign trans_valid = (bus_req_i.htrans == HTRANS_NONSEQ) ||
                         (bus_req_i.htrans == HTRANS_SEQ);

    // --------------------------------------------------------------------
    // Address phase decode
    // --------------------------------------------------------------------
    always_comb begin
        hsel_o  = '0;
        owner_d = DEFAULT;
        case (region)
            REGION_ITCM: begin
                hsel_o[ITCM] = 1'b1;
                owner_d      = ITCM;
            end
            REGION_DTCM: begin
                hsel_o[DTCM] = 1'b1;
                owner_d      = DTCM;
            end
            REGION_APB: begin
                hsel_o[APB] = 1'b1;
                owner_d     = APB;
            end
            default: owner_d = DEFAULT;
        endcase
    end

    // Owner only moves on an edge with hready high
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            owner_q <= DEFAULT;
            err_q   <= ERR_IDLE;
        end else if (bus_rsp_o.hready) begin
            if (trans_valid) begin
                owner_q <= owner_d;
                if (owner_d == DEFAULT) begin
                    err_q <= ERR_WAIT;
                end else begin
                    err_q <= ERR_IDLE;
                end
            end else begin
                owner_q <= DEFAULT;
                err_q   <= ERR_IDLE;
            end
        end else if (err_q == ERR_WAIT) begin
            err_q <= ERR_LAST;
        end
    end

    // --------------------------------------------------------------------
    // Response mux and built-in error slave
    // --------------------------------------------------------------------
    always_comb begin
        bus_rsp_o.hready = 1'b1;
        bus_rsp_o.hresp  = HRESP_OKAY;
        bus_rsp_o.hrdata = '0;
        case (owner_q)
            ITCM: bus_rsp_o = itcm_rsp_i;
            DTCM: bus_rsp_o = dtcm_rsp_i;
            APB:  bus_rsp_o = apb_rsp_i;
            default: begin
                if (err_q == ERR_WAIT) begin
                    bus_rsp_o.hready = 1'b0;
                    bus_rsp_o.hresp  = HRESP_ERROR;
                end else if (err_q == ERR_LAST) begin
                    bus_rsp_o.hresp = HRESP_ERROR;
                end
            end
        endcase
    end

    // At most one select and an ERROR for any accepted unselected transfer
    a_hsel_onehot: assert property (@(posedge clk) disable iff (!RSTn)
        $onehot0(hsel_o) &&
        (!$past(bus_rsp_o.hready && trans_valid && (hsel_o == '0)) ||
         (bus_rsp_o.hresp == HRESP_ERROR)));

    // Any slave's error must finish with the second, ready cycle
    a_error_two_cycle: assert property (@(posedge clk) disable iff (!RSTn)
        (!bus_rsp_o.hready && bus_rsp_o.hresp == HRESP_ERROR)
        |=> (bus_rsp_o.hready && bus_rsp_o.hresp == HRESP_ERROR));

endmodule

// File: rtl/ahb_sram.sv
`timescale 1ns/10ps

module ahb_sram #(
    parameter int MEM_WORDS = soc_map_pkg::ITCM_WORDS
) (
    input  logic              clk,
    input  logic              RSTn,
    input  logic              hsel_i,
    input  logic              hready_i,
    input  ahb_pkg::ahb_req_t bus_req_i,
    input  ahb_pkg::hdata_t   hwdata_i,
    output ahb_pkg::ahb_rsp_t rsp_o
);
    import ahb_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    hdata_t           mem [MEM_WORDS];
    logic             accept;
    logic             wr_pend_q;
    logic [IDX_W-1:0] idx_q;
    hsize_e           size_q;
    logic [1:0]       addr_lo_q;
    hstrb_t           wr_strb;

    assign accept = hsel_i && hready_i &&
                    ((bus_req_i.htrans == HTRANS_NONSEQ) ||
                     (bus_req_i.htrans == HTRANS_SEQ));

    // --------------------------------------------------------------------
    // Address phase capture
    // --------------------------------------------------------------------
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            wr_pend_q <= 1'b0;
        end else if (hready_i) begin
            wr_pend_q <= accept && bus_req_i.hwrite;
        end
    end

    // Word index wraps at the memory depth
    always_ff @(posedge clk) begin
        if (accept) begin
            idx_q     <= IDX_W'(bus_req_i.haddr[31:2] % MEM_WORDS);
            size_q    <= bus_req_i.hsize;
            addr_lo_q <= bus_req_i.haddr[1:0];
        end
    end

    // --------------------------------------------------------------------
    // Data phase write with byte lanes
    // --------------------------------------------------------------------
    assign wr_strb = size_to_strb(size_q, addr_lo_q);

    always_ff @(posedge clk) begin
        if (wr_pend_q && hready_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_strb[b]) begin
                    mem[idx_q][8*b +: 8] <= hwdata_i[8*b +: 8];
                end
            end
        end
    end

    // Zero wait states and the whole word returned
    assign rsp_o.hready = 1'b1;
    assign rsp_o.hresp  = HRESP_OKAY;
    assign rsp_o.hrdata = mem[idx_q];

    a_size_aligned: assert property (@(posedge clk) disable iff (!RSTn)
        accept |->
            ((bus_req_i.hsize != HSIZE_HALF) || !bus_req_i.haddr[0]) &&
            ((bus_req_i.hsize != HSIZE_WORD) || (bus_req_i.haddr[1:0] == 2'b00)));

endmodule

// File: rtl/ahb2apb_bridge.sv
`timescale 1ns/10ps

module ahb2apb_bridge #(
    parameter int DIV_WIDTH = soc_map_pkg::DIV_WIDTH
) (
    input  logic                 clk,
    input  logic                 RSTn,
    input  logic [DIV_WIDTH-1:0] div_factor_i,
    input  logic                 hsel_i,
    input  logic                 hready_i,
    input  ahb_pkg::ahb_req_t    bus_req_i,
    input  ahb_pkg::hdata_t      hwdata_i,
    output ahb_pkg::ahb_rsp_t    rsp_o,
    output logic                 pclk_en_o,
    output ahb_pkg::apb_req_t    apb_req_o,
    input  ahb_pkg::apb_rsp_t    apb_rsp_i
);
    import ahb_pkg::*;
    import soc_map_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_WAIT_EN,
        ST_SETUP,
        ST_ACCESS,
        ST_ERROR
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [DIV_WIDTH-1:0] div_cnt_q;
    logic                 pclk_en;
    logic                 accept;
    logic                 slot_hit;
    logic                 apb_done;
    logic                 err_second_q;
    paddr_t               paddr_q;
    logic                 write_q;
    hstrb_t               strb_q;
    hdata_t               wdata_q;

    // --------------------------------------------------------------------
    // APB clock enable pulsing once every div_factor + 1 cycles
    // --------------------------------------------------------------------
    assign pclk_en   = (div_cnt_q >= div_factor_i);
    assign pclk_en_o = pclk_en;

    assign accept   = hsel_i && hready_i &&
                      ((bus_req_i.htrans == HTRANS_NONSEQ) ||
                       (bus_req_i.htrans == HTRANS_SEQ));
    assign slot_hit = (bus_req_i.haddr[APB_SLOT_LSB +: 4] == APB_SLOT_MEM);
    assign apb_done = pclk_en && apb_rsp_i.pready;

    // --------------------------------------------------------------------
    // Transfer sequencer
    // --------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_WAIT_EN: if (pclk_en) state_d = ST_SETUP;
            ST_SETUP:   if (pclk_en) state_d = ST_ACCESS;
            ST_ACCESS: begin
                if (apb_done) begin
                    if (apb_rsp_i.pslverr) begin
                        state_d = ST_ERROR;
                    end else begin
                        state_d = ST_IDLE;
                    end
                end
            end
            ST_ERROR:   if (err_second_q) state_d = ST_IDLE;
            default:    state_d = ST_IDLE;
        endcase
        // Only reachable while this bridge shows hready high
        if (accept) begin
            if (slot_hit) begin
                state_d = ST_WAIT_EN;
            end else begin
                state_d = ST_ERROR;
            end
        end
    end

    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            state_q      <= ST_IDLE;
            div_cnt_q    <= '0;
            err_second_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            div_cnt_q    <= pclk_en ? '0 : div_cnt_q + 1'b1;
            err_second_q <= (state_q == ST_ERROR) && !err_second_q;
        end
    end

    // Held through the whole APB cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            paddr_q <= bus_req_i.haddr[15:0];
            write_q <= bus_req_i.hwrite;
            strb_q  <= size_to_strb(bus_req_i.hsize, bus_req_i.haddr[1:0]);
        end
        if (state_q == ST_WAIT_EN) begin
            wdata_q <= hwdata_i;
        end
    end

    // --------------------------------------------------------------------
    // AHB response and APB request
    // --------------------------------------------------------------------
    always_comb begin
        rsp_o.hready = 1'b1;
        rsp_o.hresp  = HRESP_OKAY;
        rsp_o.hrdata = apb_rsp_i.prdata;
        case (state_q)
            ST_WAIT_EN, ST_SETUP: rsp_o.hready = 1'b0;
            ST_ACCESS: rsp_o.hready = apb_done && !apb_rsp_i.pslverr;
            ST_ERROR: begin
                rsp_o.hready = err_second_q;
                rsp_o.hresp  = HRESP_ERROR;
            end
            default: rsp_o.hready = 1'b1;
        endcase
    end

    assign apb_req_o.paddr   = paddr_q;
    assign apb_req_o.psel    = (state_q == ST_SETUP) || (state_q == ST_ACCESS);
    assign apb_req_o.penable = (state_q == ST_ACCESS);
    assign apb_req_o.pwrite  = write_q;
    assign apb_req_o.pwdata  = wdata_q;
    assign apb_req_o.pstrb   = write_q ? strb_q : '0;

    // Access follows a setup phase with the address held
    a_penable_psel: assert property (@(posedge clk) disable iff (!RSTn)
        apb_req_o.penable |-> apb_req_o.psel && $past(apb_req_o.psel) &&
            $stable(apb_req_o.paddr));

endmodule

// File: rtl/apb_sram.sv
`timescale 1ns/10ps

module apb_sram #(
    parameter int MEM_WORDS = soc_map_pkg::APB_MEM_WORDS
) (
    input  logic              clk,
    input  logic              RSTn,
    input  logic              clk_en_i,
    input  ahb_pkg::apb_req_t apb_req_i,
    output ahb_pkg::apb_rsp_t apb_rsp_o
);
    import ahb_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    hdata_t           mem [MEM_WORDS];
    logic [13:0]      word;
    logic [IDX_W-1:0] idx;
    logic             oob;
    logic             access;
    logic             wait_q;

    assign word   = apb_req_i.paddr[15:2];
    assign idx    = IDX_W'(word);
    assign oob    = (word >= MEM_WORDS);
    assign access = apb_req_i.psel && apb_req_i.penable;

    // One wait state per access paced by the APB enable
    always_ff @(posedge clk or negedge RSTn) begin
        if (!RSTn) begin
            wait_q <= 1'b0;
        end else if (clk_en_i) begin
            wait_q <= access && !wait_q;
        end
    end

    // --------------------------------------------------------------------
    // Strobed write on the completing enable
    // --------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (clk_en_i && access && wait_q && apb_req_i.pwrite && !oob) begin
            for (int b = 0; b < 4; b++) begin
                if (apb_req_i.pstrb[b]) begin
                    mem[idx][8*b +: 8] <= apb_req_i.pwdata[8*b +: 8];
                end
            end
        end
    end

    assign apb_rsp_o.pready  = access && wait_q;
    assign apb_rsp_o.pslverr = access && wait_q && oob;
    assign apb_rsp_o.prdata  = oob ? '0 : mem[idx];

endmodule

// File: rtl/soc_fabric_top.sv
`timescale 1ns/10ps

module soc_fabric_top #(
    parameter int ITCM_WORDS    = soc_map_pkg::ITCM_WORDS,
    parameter int DTCM_WORDS    = soc_map_pkg::DTCM_WORDS,
    parameter int APB_MEM_WORDS = soc_map_pkg::APB_MEM_WORDS,
    parameter int DIV_WIDTH     = soc_map_pkg::DIV_WIDTH
) (
    input  logic                 clk,
    input  logic                 RSTn,
    input  logic [DIV_WIDTH-1:0] div_factor_i,
    input  ahb_pkg::ahb_req_t    bus_req_i,
    input  ahb_pkg::hdata_t      hwdata_i,
    output ahb_pkg::ahb_rsp_t    bus_rsp_o
);
    import ahb_pkg::*;

    logic [2:0] hsel;
    ahb_rsp_t   itcm_rsp;
    ahb_rsp_t   dtcm_rsp;
    ahb_rsp_t   bridge_rsp;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    logic       pclk_en;

    // --------------------------------------------------------------------
    // AHB side
    // --------------------------------------------------------------------
    ahb_decoder u_decoder (
        .clk        (clk),
        .RSTn       (RSTn),
        .bus_req_i  (bus_req_i),
        .hsel_o     (hsel),
        .itcm_rsp_i (itcm_rsp),
        .dtcm_rsp_i (dtcm_rsp),
        .apb_rsp_i  (bridge_rsp),
        .bus_rsp_o  (bus_rsp_o)
    );

    ahb_sram #(.MEM_WORDS(ITCM_WORDS)) itcm_mem (
        .clk       (clk),
        .RSTn      (RSTn),
        .hsel_i    (hsel[0]),
        .hready_i  (bus_rsp_o.hready),
        .bus_req_i (bus_req_i),
        .hwdata_i  (hwdata_i),
        .rsp_o     (itcm_rsp)
    );

    ahb_sram #(.MEM_WORDS(DTCM_WORDS)) dtcm_mem (
        .clk       (clk),
        .RSTn      (RSTn),
        .hsel_i    (hsel[1]),
        .hready_i  (bus_rsp_o.hready),
        .bus_req_i (bus_req_i),
        .hwdata_i  (hwdata_i),
        .rsp_o     (dtcm_rsp)
    );

    // --------------------------------------------------------------------
    // APB side
    // --------------------------------------------------------------------
    ahb2apb_bridge #(.DIV_WIDTH(DIV_WIDTH)) u_bridge (
        .clk          (clk),
        .RSTn         (RSTn),
        .div_factor_i (div_factor_i),
        .hsel_i       (hsel[2]),
        .hready_i     (bus_rsp_o.hready),
        .bus_req_i    (bus_req_i),
        .hwdata_i     (hwdata_i),
        .rsp_o        (bridge_rsp),
        .pclk_en_o    (pclk_en),
        .apb_req_o    (apb_req),
        .apb_rsp_i    (apb_rsp)
    );

    // Slot 3 memory
    apb_sram #(.MEM_WORDS(APB_MEM_WORDS)) u_apb_mem (
        .clk       (clk),
        .RSTn      (RSTn),
        .clk_en_i  (pclk_en),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

endmodule

// File: bench/tb_soc_fabric.sv
`timescale 1ns/10ps

module tb_soc_fabric;
    import ahb_pkg::*;
    import soc_map_pkg::*;

    localparam int RESET_CYCLES = 16;

    // One line of the pattern file
    typedef struct packed {
        logic [7:0]  op;
        logic [2:0]  size;
        logic [31:0] addr;
        logic [31:0] data;
        logic        resp;
    } pattern_t;

    logic                 clk;
    logic                 RSTn;
    logic [DIV_WIDTH-1:0] div_factor;
    ahb_req_t             bus_req;
    hdata_t               hwdata;
    ahb_rsp_t             bus_rsp;

    pattern_t    patterns[$];
    logic [7:0]  ref_mem[logic [31:0]];
    logic [15:0] lfsr_q;
    pattern_t    pend;
    logic        pend_valid;
    int          cur_div;
    int          errors;
    int          checks;
    int unsigned cycle_count;
    int unsigned cycle_limit;

    soc_fabric_top #(
        .ITCM_WORDS    (ITCM_WORDS),
        .DTCM_WORDS    (DTCM_WORDS),
        .APB_MEM_WORDS (APB_MEM_WORDS),
        .DIV_WIDTH     (DIV_WIDTH)
    ) UUT (
        .clk          (clk),
        .RSTn         (RSTn),
        .div_factor_i (div_factor),
        .bus_req_i    (bus_req),
        .hwdata_i     (hwdata),
        .bus_rsp_o    (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------------------------------------------------------
    // Helpers
    // --------------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_random(input int nbits, output int value);
        value = 0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            value  = (value << 1) | int'(lfsr_q[0]);
        end
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("[FAIL] %0t: %s", $time, msg);
    endtask

    // Byte lanes covered by a naturally aligned transfer
    function automatic logic [3:0] lanes_of(input logic [2:0] size, input logic [31:0] addr);
        int         nbytes;
        int         first;
        logic [3:0] lanes;
        nbytes = 1 << size;
        first  = int'(addr[1:0]) & ~(nbytes - 1);
        for (int b = 0; b < 4; b++) begin
            lanes[b] = (b >= first) && (b < first + nbytes);
        end
        return lanes;
    endfunction

    task automatic model_write(input pattern_t p);
        logic [3:0] lanes;
        lanes = lanes_of(p.size, p.addr);
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                ref_mem[{p.addr[31:2], 2'b00} + b] = p.data[8*b +: 8];
            end
        end
    endtask

    task automatic model_read(input logic [31:0] addr, output logic [31:0] word,
                              output logic known);
        logic [31:0] base;
        base  = {addr[31:2], 2'b00};
        known = 1'b1;
        word  = '0;
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists(base + b)) begin
                word[8*b +: 8] = ref_mem[base + b];
            end else begin
                known = 1'b0;
            end
        end
    endtask

    task automatic read_patterns();
        int          fd;
        int          n;
        string       line;
        pattern_t    p;
        logic [7:0]  op_c;
        logic [31:0] size_v;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        logic [31:0] resp_v;
        fd = $fopen("bench/ahb_patterns.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open bench/ahb_patterns.txt for reading");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%s %h %h %h %h", op_c, size_v, addr_v, data_v, resp_v);
                if (n == 5 && op_c != "#") begin
                    p.op   = op_c;
                    p.size = size_v[2:0];
                    p.addr = addr_v;
                    p.data = data_v;
                    p.resp = resp_v[0];
                    patterns.push_back(p);
                end
            end
            $fclose(fd);
        end
    endtask

    // --------------------------------------------------------------------
    // AHB master
    // --------------------------------------------------------------------
    task automatic wait_ready(output ahb_rsp_t rsp, output int waits, output hresp_e prev);
        waits = 0;
        prev  = HRESP_OKAY;
        @(negedge clk);
        while (!bus_rsp.hready) begin
            waits++;
            prev = bus_rsp.hresp;
            @(negedge clk);
        end
        rsp = bus_rsp;
        @(posedge clk);
        #1;
    endtask

    task automatic check_response(input pattern_t p, input ahb_rsp_t rsp, input int waits,
                                  input hresp_e prev);
        logic [31:0] model_word;
        logic        known;
        logic [3:0]  region;
        region = p.addr[31:28];
        checks++;
        if (rsp.hresp !== (p.resp ? HRESP_ERROR : HRESP_OKAY)) begin
            report_fail($sformatf("%s %08h: hresp %0d, expected %0d",
                                  p.op, p.addr, rsp.hresp, p.resp));
        end
        if (p.resp) begin
            checks++;
            if (waits == 0 || prev != HRESP_ERROR) begin
                report_fail($sformatf("%s %08h: ERROR not preceded by a wait cycle",
                                      p.op, p.addr));
            end
        end else begin
            checks++;
            if ((region == 4'h0 || region == 4'h2) && waits != 0) begin
                report_fail($sformatf("%08h: %0d wait states on a TCM", p.addr, waits));
            end
            if (region == 4'h4 && waits < 3 * cur_div + 2) begin
                report_fail($sformatf("%08h: only %0d wait states at divide %0d",
                                      p.addr, waits, cur_div));
            end
            if (p.op == "R") begin
                checks++;
                if (rsp.hrdata !== p.data) begin
                    report_fail($sformatf("R %08h: hrdata %08h, file expects %08h",
                                          p.addr, rsp.hrdata, p.data));
                end
                model_read(p.addr, model_word, known);
                if (known) begin
                    checks++;
                    if (rsp.hrdata !== model_word) begin
                        report_fail($sformatf("R %08h: hrdata %08h, model holds %08h",
                                              p.addr, rsp.hrdata, model_word));
                    end
                end
            end else begin
                model_write(p);
            end
        end
    endtask

    task automatic finish_pending();
        ahb_rsp_t rsp;
        int       waits;
        hresp_e   prev;
        if (pend_valid) begin
            bus_req.htrans = HTRANS_IDLE;
            bus_req.hwrite = 1'b0;
            wait_ready(rsp, waits, prev);
            check_response(pend, rsp, waits, prev);
            pend_valid = 1'b0;
        end
    endtask

    // Back to back puts the address on the bus during the previous data phase
    task automatic issue_transfer(input pattern_t p, input logic back_to_back);
        ahb_rsp_t rsp;
        int       waits;
        hresp_e   prev;
        int       idle;
        if (!back_to_back) begin
            finish_pending();
            take_random(2, idle);
            repeat (idle) begin
                @(posedge clk);
                #1;
            end
        end
        bus_req.haddr  = p.addr;
        bus_req.htrans = HTRANS_NONSEQ;
        bus_req.hsize  = hsize_e'(p.size);
        bus_req.hwrite = (p.op == "W");
        wait_ready(rsp, waits, prev);
        if (pend_valid) begin
            check_response(pend, rsp, waits, prev);
        end
        pend       = p;
        pend_valid = 1'b1;
        hwdata     = (p.op == "W") ? p.data : '0;
    endtask

    // --------------------------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------------------------
    initial begin
        int max_div;
        int xfer_count;
        RSTn        = 1'b0;
        div_factor  = '0;
        bus_req     = '0;
        hwdata      = '0;
        lfsr_q      = 16'd27557;
        pend_valid  = 1'b0;
        cur_div     = 0;
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        cycle_limit = 0;
        read_patterns();
        max_div = 0;
        foreach (patterns[i]) begin
            if (patterns[i].op == "D" && int'(patterns[i].data) > max_div) begin
                max_div = int'(patterns[i].data);
            end
        end
        cycle_limit = patterns.size() * (16 * max_div + 8) + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        RSTn = 1'b1;
        @(negedge clk);
        checks++;
        if (!bus_rsp.hready || bus_rsp.hresp != HRESP_OKAY) begin
            report_fail("bus not ready with OKAY right after reset");
        end
        @(posedge clk);
        #1;
        xfer_count = 0;
        foreach (patterns[i]) begin
            if (patterns[i].op == "D") begin
                finish_pending();
                div_factor = patterns[i].data[DIV_WIDTH-1:0];
                cur_div    = int'(div_factor);
            end else begin
                issue_transfer(patterns[i], (xfer_count % 4) == 3);
                xfer_count++;
            end
        end
        finish_pending();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (cycle_limit != 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: transfers did not finish within %0d cycles", cycle_limit);
        $display("Test failed");
        $finish;
    end

endmodule

// File: bench/ahb_patterns.txt
# op size addr data resp: op is W write, R read, D divide factor (taken from data)
# size 0 byte, 1 halfword, 2 word; resp 0 OKAY, 1 ERROR; R data is the expected word
D 0 00000000 00000000 0
W 2 00000010 11223344 0
W 2 20000010 a5a5a5a5 0
W 0 00000011 0000ee00 0
R 2 00000010 1122ee44 0
W 1 20000012 beef0000 0
W 0 20000010 00000077 0
W 2 40030004 cafef00d 0
R 2 00000010 1122ee44 0
R 2 20000010 beefa577 0
R 2 40030004 cafef00d 0
W 2 00000020 01020304 0
R 2 40030004 cafef00d 0
D 0 00000000 00000003 0
W 1 40030006 55660000 0
R 2 40030004 5566f00d 0
W 2 70000010 deadbeef 1
R 2 f0000010 00000000 1
W 2 40010004 deadbeef 1
R 2 40030004 5566f00d 0
D 0 00000000 0000000f 0
W 2 40030008 0badc0de 0
R 2 40030008 0badc0de 0
R 2 00000010 1122ee44 0
R 2 20000010 beefa577 0
W 0 40030009 00007700 0
R 2 40030008 0bad77de 0

// File: flist.f
rtl/ahb_pkg.sv
rtl/soc_map_pkg.sv
rtl/ahb_decoder.sv
rtl/ahb_sram.sv
rtl/ahb2apb_bridge.sv
rtl/apb_sram.sv
rtl/soc_fabric_top.sv
bench/tb_soc_fabric.sv

// File: Makefile
TOP = tb_soc_fabric

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f flist.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module soc_fabric_top \
		rtl/ahb_pkg.sv rtl/soc_map_pkg.sv rtl/ahb_decoder.sv rtl/ahb_sram.sv \
		rtl/ahb2apb_bridge.sv rtl/apb_sram.sv rtl/soc_fabric_top.sv

clean:
	rm -rf obj_dir sim.log
